/* all.f */
logic/cache_pkg.sv
logic/tag_store.sv
logic/line_store.sv
logic/cache_ctrl.sv
logic/cache_top.sv
verif/mem_model.sv
verif/cache_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = cache_tb
FILELIST = all.f
RTL_TOP  = cache_top
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)
	$(TOOL) --lint-only --top-module $(RTL_TOP) logic/cache_pkg.sv logic/tag_store.sv \
		logic/line_store.sv logic/cache_ctrl.sv logic/cache_top.sv

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verif/cache_tb.sv */
// Data cache testbench
`timescale 1ns/1ps

module cache_tb import cache_pkg::*; ();

    localparam int WAIT_LIMIT  = 60;
    localparam int SHADOW_SIZE = 1 << (MEM_ADDR_W + OFFSET_W);
    localparam int RAND_OPS    = 40;

    logic      clk;
    logic      rst;
    addr_t     cpu_addr;
    word_t     cpu_wdata;
    size_t     cpu_size;
    logic      cpu_wr;
    word_t     cpu_rdata;
    logic      cpu_ready;
    logic      cpu_wait;
    line_t     mem_rdata;
    mem_addr_t mem_addr;
    line_t     mem_wdata;
    logic      mem_wren;

    logic [7:0] shadow [SHADOW_SIZE];  // Architectural memory view

    integer    seed;
    word_t     last_rdata;
    int        wait_cnt;
    int        wren_cnt;
    mem_addr_t wb_addr;
    line_t     wb_data;
    index_t    idx_set [4];
    tag_t      tag_a [4];
    tag_t      tag_b [4];

    cache_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_size  (cpu_size),
        .cpu_wr    (cpu_wr),
        .cpu_rdata (cpu_rdata),
        .cpu_ready (cpu_ready),
        .cpu_wait  (cpu_wait),
        .mem_rdata (mem_rdata),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_wren  (mem_wren)
    );

    mem_model u_mem (
        .clk       (clk),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_wren  (mem_wren),
        .mem_rdata (mem_rdata)
    );

    always #10 clk = ~clk;

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    function automatic addr_t make_addr(input tag_t t, input index_t i, input offset_t o);
        return {14'b0, t, i, o};
    endfunction

    function automatic int lane_bytes(input size_t s);
        return (s == SIZE_WORD) ? 4 : ((s == SIZE_HALF) ? 2 : 1);
    endfunction

    // Expected read aligned down and zero-extended
    function automatic word_t expect_read(input addr_t a, input size_t s);
        word_t r;
        int    base;
        r    = '0;
        base = int'(a[17:0]) & ~(lane_bytes(s) - 1);
        for (int b = 0; b < lane_bytes(s); b++) begin
            r[b*8 +: 8] = shadow[base + b];
        end
        return r;
    endfunction

    task automatic apply_write(input addr_t a, input size_t s, input word_t d);
        int base;
        base = int'(a[17:0]) & ~(lane_bytes(s) - 1);
        for (int b = 0; b < lane_bytes(s); b++) begin
            shadow[base + b] = d[b*8 +: 8];
        end
    endtask

    function automatic line_t shadow_line(input mem_addr_t la);
        line_t l;
        for (int b = 0; b < LINE_BYTES; b++) begin
            l[b*8 +: 8] = shadow[int'(la) * LINE_BYTES + b];
        end
        return l;
    endfunction

    // One CPU request held until accepted
    task automatic do_access(input addr_t a, input size_t s, input logic wr, input word_t d);
        int   cycles;
        logic done;
        cpu_addr  = a;
        cpu_size  = s;
        cpu_wr    = wr;
        cpu_wdata = d;
        wait_cnt  = 0;
        wren_cnt  = 0;
        cycles    = 0;
        done      = 1'b0;
        while (!done) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                fail_now("timeout waiting for the cache to accept a request");
            end
            if (mem_wren) begin
                wren_cnt++;
                wb_addr = mem_addr;
                wb_data = mem_wdata;
            end
            if (cpu_wait) wait_cnt++;
            if (cpu_ready && !cpu_wait) begin
                last_rdata = cpu_rdata;
                done       = 1'b1;
            end
        end
        if (wr) begin  // Writes hold through the write hit cycle
            @(negedge clk);
            assert (cpu_wait) else fail_now("write hit cycle missing after cpu_ready");
            assert (!mem_wren) else fail_now("unexpected mem_wren during a write hit");
            wait_cnt++;
        end
        @(posedge clk);
        #2;
        cpu_size = SIZE_NONE;
        cpu_wr   = 1'b0;
        if (wr) apply_write(a, s, d);
    endtask

    task automatic check_read(input addr_t a, input size_t s);
        do_access(a, s, 1'b0, '0);
        assert (last_rdata == expect_read(a, s)) else fail_now($sformatf(
            "mismatch cpu_rdata: addr %h got %h expected %h", a, last_rdata,
            expect_read(a, s)));
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        assert (got == exp) else fail_now($sformatf("mismatch %s: got %h expected %h",
            name, got, exp));
    endtask

    initial begin
        addr_t a;
        addr_t b;
        word_t d;
        size_t s;
        int    k;
        int    v;
        seed      = 74;
        clk       = 1'b0;
        rst       = 1'b1;
        cpu_addr  = '0;
        cpu_wdata = '0;
        cpu_size  = SIZE_NONE;
        cpu_wr    = 1'b0;
        for (int i = 0; i < SHADOW_SIZE; i++) begin
            v         = i;  // Byte address equals line*16+byte
            shadow[i] = v[7:0] ^ 8'h5a;
        end
        for (int i = 0; i < 4; i++) begin
            idx_set[i] = index_t'($random(seed));
            tag_a[i]   = tag_t'($random(seed));
            tag_b[i]   = tag_a[i] ^ tag_t'(7'h2b);  // Always a different tag
        end
        idx_set[1] = idx_set[0] ^ index_t'(1);  // Distinct slots for the fixed cases
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;

        // Read miss then read hit
        a = make_addr(tag_a[0], idx_set[0], 4'h4);
        check_read(a, SIZE_WORD);
        check_count("miss cpu_wait cycles", wait_cnt, MEM_DELAY_CYCLES);
        check_count("mem_wren pulses", wren_cnt, 0);
        check_read(a, SIZE_WORD);
        check_count("hit cpu_wait cycles", wait_cnt, 0);

        // Every lane and offset
        for (int sz = 1; sz < 4; sz++) begin
            for (int o = 0; o < 16; o++) begin
                check_read(make_addr(tag_a[0], idx_set[0], offset_t'(o)), size_t'(sz));
                check_count("hit cpu_wait cycles", wait_cnt, 0);
            end
        end

        // Write hit of each size
        for (int sz = 1; sz < 4; sz++) begin
            a = make_addr(tag_a[0], idx_set[0], offset_t'($random(seed)));
            d = word_t'($random(seed));
            do_access(a, size_t'(sz), 1'b1, d);
            check_count("write hit cpu_wait cycles", wait_cnt, 1);
            check_count("mem_wren pulses", wren_cnt, 0);
            check_read(a, size_t'(sz));
            check_count("hit cpu_wait cycles", wait_cnt, 0);  // Write hit ended in one cycle
            check_read({a[31:2], 2'b00}, SIZE_WORD);
        end

        // Write miss into a clean slot
        a = make_addr(tag_a[1], idx_set[1], 4'h9);
        do_access(a, SIZE_BYTE, 1'b1, 32'h0000_00c3);
        check_count("write miss cpu_wait cycles", wait_cnt, MEM_DELAY_CYCLES + 1);
        check_count("mem_wren pulses", wren_cnt, 0);
        check_read(a, SIZE_BYTE);
        check_count("hit cpu_wait cycles", wait_cnt, 0);
        check_read(make_addr(tag_a[1], idx_set[1], 4'h4), SIZE_WORD);

        // Dirty eviction and refetch of the old line
        b = make_addr(tag_b[0], idx_set[0], 4'h0);
        check_read(b, SIZE_WORD);
        check_count("mem_wren pulses", wren_cnt, 1);
        check_count("dirty miss cpu_wait cycles", wait_cnt, 2 * MEM_DELAY_CYCLES);
        assert (wb_addr == {tag_a[0], idx_set[0]}) else fail_now($sformatf(
            "mismatch mem_addr: got %h expected %h", wb_addr, {tag_a[0], idx_set[0]}));
        assert (wb_data == shadow_line(wb_addr)) else fail_now($sformatf(
            "mismatch mem_wdata: got %h expected %h", wb_data, shadow_line(wb_addr)));
        check_read(make_addr(tag_a[0], idx_set[0], 4'h0), SIZE_WORD);
        check_count("mem_wren pulses", wren_cnt, 0);  // Read fill left the slot clean
        check_count("clean miss cpu_wait cycles", wait_cnt, MEM_DELAY_CYCLES);
        for (int o = 4; o < 16; o += 4) begin
            check_read(make_addr(tag_a[0], idx_set[0], offset_t'(o)), SIZE_WORD);
            check_count("hit cpu_wait cycles", wait_cnt, 0);
        end

        // Random mix over a few slots
        for (int n = 0; n < RAND_OPS; n++) begin
            k = {$random(seed)} % 4;
            a = make_addr(($random(seed) & 1) ? tag_b[k] : tag_a[k], idx_set[k],
                offset_t'($random(seed)));
            s = size_t'(1 + {$random(seed)} % 3);
            if ($random(seed) & 1) begin
                do_access(a, s, 1'b1, word_t'($random(seed)));
            end else begin
                check_read(a, s);
            end
            assert (wren_cnt <= 1) else fail_now("more than one mem_wren pulse in one miss");
            if (wren_cnt == 1) begin
                assert (wb_data == shadow_line(wb_addr)) else fail_now($sformatf(
                    "mismatch mem_wdata: got %h expected %h", wb_data, shadow_line(wb_addr)));
            end
        end

        // SIZE_NONE request does nothing
        cpu_addr = make_addr(tag_b[2], idx_set[2], 4'h0);
        cpu_size = SIZE_NONE;
        cpu_wr   = 1'b1;
        repeat (8) begin
            @(negedge clk);
            assert (!cpu_ready && !cpu_wait && !mem_wren)
                else fail_now("SIZE_NONE request started an access");
        end
        cpu_wr = 1'b0;

        $display("All tests passed");
        $finish;
    end

endmodule

/* verif/mem_model.sv */
// Line-wide memory model
`timescale 1ns/1ps

module mem_model import cache_pkg::*; (
    input  logic      clk,
    input  mem_addr_t mem_addr,
    input  line_t     mem_wdata,
    input  logic      mem_wren,
    output line_t     mem_rdata
);

    localparam int MEM_LINES = 1 << MEM_ADDR_W;

    line_t mem [MEM_LINES];

    // Byte b of line a holds the low byte of a*16+b, XORed with 5A
    initial begin
        int v;
        for (int a = 0; a < MEM_LINES; a++) begin
            for (int b = 0; b < LINE_BYTES; b++) begin
                v = a * 16 + b;
                mem[a][b*8 +: 8] = v[7:0] ^ 8'h5a;
            end
        end
    end

    // Write-back capture
    always @(posedge clk) begin
        if (mem_wren) begin
            mem[mem_addr] <= mem_wdata;
        end
    end

    // The cache holds mem_addr steady for the whole wait, so the
    // line is ready well before it is sampled
    assign mem_rdata = mem[mem_addr];

endmodule

/* logic/cache_top.sv */
// Direct-mapped data cache top
`timescale 1ns/1ps

module cache_top import cache_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  addr_t     cpu_addr,
    input  word_t     cpu_wdata,
    input  size_t     cpu_size,
    input  logic      cpu_wr,
    output word_t     cpu_rdata,
    output logic      cpu_ready,
    output logic      cpu_wait,
    input  line_t     mem_rdata,
    output mem_addr_t mem_addr,
    output line_t     mem_wdata,
    output logic      mem_wren
);

    offset_t offset;
    index_t  index;
    tag_t    tag;

    logic  hit;
    logic  line_dirty;
    tag_t  line_tag;
    logic  tag_wr;
    logic  mark_dirty;
    logic  fill_clean;
    logic  line_wr;
    logic  line_from_mem;
    logic  merge_cpu;
    word_t rd_word;
    line_t rd_line;

    // Address split, upper bits beyond the tag are ignored
    assign offset = cpu_addr[OFFSET_W-1:0];
    assign index  = cpu_addr[OFFSET_W +: INDEX_W];
    assign tag    = cpu_addr[OFFSET_W + INDEX_W +: TAG_W];

    tag_store u_tag_store (
        .clk        (clk),
        .rst        (rst),
        .index      (index),
        .tag        (tag),
        .tag_wr     (tag_wr),
        .mark_dirty (mark_dirty),
        .fill_clean (fill_clean),
        .hit        (hit),
        .line_dirty (line_dirty),
        .line_tag   (line_tag)
    );

    line_store u_line_store (
        .clk           (clk),
        .index         (index),
        .offset        (offset),
        .size          (cpu_size),
        .wdata         (cpu_wdata),
        .mem_line      (mem_rdata),
        .line_wr       (line_wr),
        .line_from_mem (line_from_mem),
        .merge_cpu     (merge_cpu),
        .rd_word       (rd_word),
        .rd_line       (rd_line)
    );

    cache_ctrl u_cache_ctrl (
        .clk           (clk),
        .rst           (rst),
        .cpu_size      (cpu_size),
        .cpu_wr        (cpu_wr),
        .index         (index),
        .tag           (tag),
        .hit           (hit),
        .line_dirty    (line_dirty),
        .line_tag      (line_tag),
        .rd_line       (rd_line),
        .rd_word       (rd_word),
        .tag_wr        (tag_wr),
        .mark_dirty    (mark_dirty),
        .fill_clean    (fill_clean),
        .line_wr       (line_wr),
        .line_from_mem (line_from_mem),
        .merge_cpu     (merge_cpu),
        .cpu_rdata     (cpu_rdata),
        .cpu_ready     (cpu_ready),
        .cpu_wait      (cpu_wait),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .mem_wren      (mem_wren)
    );

endmodule

/* logic/cache_ctrl.sv */
// Cache controller FSM
`timescale 1ns/1ps

module cache_ctrl import cache_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  size_t     cpu_size,
    input  logic      cpu_wr,
    input  index_t    index,
    input  tag_t      tag,
    input  logic      hit,
    input  logic      line_dirty,
    input  tag_t      line_tag,
    input  line_t     rd_line,
    input  word_t     rd_word,
    output logic      tag_wr,
    output logic      mark_dirty,
    output logic      fill_clean,
    output logic      line_wr,
    output logic      line_from_mem,
    output logic      merge_cpu,
    output word_t     cpu_rdata,
    output logic      cpu_ready,
    output logic      cpu_wait,
    output mem_addr_t mem_addr,
    output line_t     mem_wdata,
    output logic      mem_wren
);

    typedef enum logic [1:0] {
        IDLE,
        WRITE_HIT,
        WRITE_BACK,
        FILL
    } ctrl_state_t;

    ctrl_state_t state;
    delay_cnt_t  delay_cnt;

    logic req_valid;
    logic miss_req;
    logic delay_done;
    logic fill_end;
    logic wb_to_fill;

    assign req_valid  = (cpu_size != SIZE_NONE);
    assign miss_req   = (state == IDLE) && req_valid && !hit;
    assign delay_done = (delay_cnt == DELAY_LAST);
    assign fill_end   = (state == FILL) && delay_done;        // Memory line sampled here
    assign wb_to_fill = (state == WRITE_BACK) && delay_done;

    // CPU side
    assign cpu_ready = (state == IDLE) && req_valid && hit;
    assign cpu_wait  = (state != IDLE);
    assign cpu_rdata = cpu_ready ? rd_word : '0;

    // Array update strobes
    assign line_wr       = (state == WRITE_HIT) || fill_end;
    assign merge_cpu     = (state == WRITE_HIT) || (fill_end && cpu_wr);
    assign mark_dirty    = merge_cpu;
    assign line_from_mem = fill_end;
    assign tag_wr        = fill_end;
    assign fill_clean    = fill_end && !cpu_wr;  // Read fill matches memory

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            delay_cnt <= '0;
            mem_wren  <= 1'b0;
        end else begin
            mem_wren <= 1'b0;  // Single-cycle pulse
            case (state)
                IDLE: begin
                    if (req_valid) begin
                        if (hit) begin
                            if (cpu_wr) begin
                                state <= WRITE_HIT;
                            end
                        end else if (line_dirty) begin
                            state    <= WRITE_BACK;
                            mem_wren <= 1'b1;  // Old line goes out first
                        end else begin
                            state <= FILL;
                        end
                    end
                end
                WRITE_HIT: begin
                    state <= IDLE;
                end
                WRITE_BACK: begin
                    if (delay_done) begin
                        state     <= FILL;
                        delay_cnt <= '0;
                    end else begin
                        delay_cnt <= delay_cnt + 1'b1;
                    end
                end
                FILL: begin
                    if (delay_done) begin
                        state     <= IDLE;
                        delay_cnt <= '0;
                    end else begin
                        delay_cnt <= delay_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Memory address and write data
    always_ff @(posedge clk) begin
        if (miss_req) begin
            if (line_dirty) begin
                mem_addr  <= {line_tag, index};  // Victim line address
                mem_wdata <= rd_line;
            end else begin
                mem_addr <= {tag, index};
            end
        end else if (wb_to_fill) begin
            mem_addr <= {tag, index};  // Switch to the refill address
        end
    end

endmodule

/* logic/line_store.sv */
// Cache line data array
`timescale 1ns/1ps

module line_store import cache_pkg::*; (
    input  logic    clk,
    input  index_t  index,
    input  offset_t offset,
    input  size_t   size,
    input  word_t   wdata,
    input  line_t   mem_line,
    input  logic    line_wr,
    input  logic    line_from_mem,
    input  logic    merge_cpu,
    output word_t   rd_word,
    output line_t   rd_line
);

    line_t data_mem [CACHE_DEPTH];

    line_t cur_line;
    line_t base_line;
    line_t wr_line;
    line_t wdata_rep;
    logic [LINE_BYTES-1:0] byte_en;

    assign cur_line = data_mem[index];
    assign rd_line  = cur_line;  // Also the write-back data

    // Read lane select, misaligned offsets round down
    always_comb begin
        case (size)
            SIZE_BYTE: begin
                rd_word = {24'b0, cur_line[{offset, 3'b000} +: 8]};
            end
            SIZE_HALF: begin
                rd_word = {16'b0, cur_line[{offset[3:1], 4'b0000} +: 16]};
            end
            SIZE_WORD: begin
                rd_word = cur_line[{offset[3:2], 5'b00000} +: 32];
            end
            default: begin
                rd_word = '0;
            end
        endcase
    end

    // Write data copied into every lane of its size
    always_comb begin
        case (size)
            SIZE_BYTE: begin
                wdata_rep = {LINE_BYTES{wdata[7:0]}};
                byte_en   = LINE_BYTES'(1) << offset;
            end
            SIZE_HALF: begin
                wdata_rep = {(LINE_BYTES / 2){wdata[15:0]}};
                byte_en   = LINE_BYTES'(2'b11) << {offset[3:1], 1'b0};
            end
            SIZE_WORD: begin
                wdata_rep = {(LINE_BYTES / 4){wdata}};
                byte_en   = LINE_BYTES'(4'hf) << {offset[3:2], 2'b00};
            end
            default: begin
                wdata_rep = '0;
                byte_en   = '0;  // Nothing to merge
            end
        endcase
    end

    assign base_line = line_from_mem ? mem_line : cur_line;

    // Overlay the CPU bytes on the base line
    always_comb begin
        wr_line = base_line;
        if (merge_cpu) begin
            for (int i = 0; i < LINE_BYTES; i++) begin
                if (byte_en[i]) begin
                    wr_line[i*8 +: 8] = wdata_rep[i*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (line_wr) begin
            data_mem[index] <= wr_line;
        end
    end

endmodule

/* logic/tag_store.sv */
// Cache tag and state arrays
`timescale 1ns/1ps

module tag_store import cache_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  index_t index,
    input  tag_t   tag,
    input  logic   tag_wr,
    input  logic   mark_dirty,
    input  logic   fill_clean,
    output logic   hit,
    output logic   line_dirty,
    output tag_t   line_tag
);

    tag_t tag_mem [CACHE_DEPTH];
    logic [CACHE_DEPTH-1:0] valid;
    logic [CACHE_DEPTH-1:0] dirty;

    // Stored tag only means something once valid is set
    always_ff @(posedge clk) begin
        if (tag_wr) begin
            tag_mem[index] <= tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            dirty <= '0;
        end else begin
            if (tag_wr) begin
                valid[index] <= 1'b1;  // Line now holds the fetched tag
            end

            // A read fill leaves the line clean, any CPU write dirties it
            if (fill_clean) begin
                dirty[index] <= 1'b0;
            end else if (mark_dirty) begin
                dirty[index] <= 1'b1;
            end
        end
    end

    // Lookup at the requested index
    assign line_tag   = tag_mem[index];
    assign hit        = valid[index] && (tag_mem[index] == tag);
    assign line_dirty = valid[index] && dirty[index];  // Needs write-back before refill

endmodule

/* logic/cache_pkg.sv */
// Data cache shared definitions
package cache_pkg;

    // Field widths
    localparam int WORD_W     = 32;
    localparam int LINE_W     = 128;
    localparam int OFFSET_W   = 4;
    localparam int INDEX_W    = 7;
    localparam int TAG_W      = 7;
    localparam int MEM_ADDR_W = TAG_W + INDEX_W;  // Tag then index
    localparam int LINE_BYTES = LINE_W / 8;

    localparam int CACHE_DEPTH = 1 << INDEX_W;  // 128 lines

    // Memory latency in cycles, at least 2
    localparam int MEM_DELAY_CYCLES = 5;
    localparam int DELAY_CNT_W      = $clog2(MEM_DELAY_CYCLES);

    typedef logic [31:0]             addr_t;
    typedef logic [WORD_W-1:0]       word_t;
    typedef logic [LINE_W-1:0]       line_t;
    typedef logic [OFFSET_W-1:0]     offset_t;
    typedef logic [INDEX_W-1:0]      index_t;
    typedef logic [TAG_W-1:0]        tag_t;
    typedef logic [MEM_ADDR_W-1:0]   mem_addr_t;
    typedef logic [1:0]              size_t;
    typedef logic [DELAY_CNT_W-1:0]  delay_cnt_t;

    // Last cycle of a memory wait
    localparam delay_cnt_t DELAY_LAST = delay_cnt_t'(MEM_DELAY_CYCLES - 1);

    // Access size codes
    localparam size_t SIZE_NONE = 2'd0;  // No access
    localparam size_t SIZE_BYTE = 2'd1;
    localparam size_t SIZE_HALF = 2'd2;
    localparam size_t SIZE_WORD = 2'd3;

endpackage
